// File: verilog.f
+incdir+include
hw/lc3IsaPkg.sv
hw/lc3CtrlPkg.sv
hw/isdu.sv
hw/lc3RegFile.sv
hw/lc3Datapath.sv
hw/lc3Top.sv
test/lc3_sva.sv
test/lc3Tb.sv

// File: run.sh
#!/bin/sh
# Build the LC-3 testbench with Verilator, run it and look for the pass message
verilator --binary --assert --timing --timescale 1ns/100ps \
	-f verilog.f --top-module lc3Tb -o lc3Sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/lc3Sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: test/lc3Tb.sv
// LC-3 subset processor testbench
`include "lc3_consts.svh"

module lc3Tb
	import lc3IsaPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeoutCycles = 3000;  // Program runs a few hundred cycles
	localparam wordT baseAddr  = 16'h0040;  // R6, data words at +0 to +3
	localparam wordT addAddr   = 16'h0044;
	localparam wordT andAddr   = 16'h0045;
	localparam wordT andIAddr  = 16'h0046;
	localparam wordT notAddr   = 16'h0047;
	localparam wordT forbidAddr = 16'h0048;  // Skipped by the taken BRz
	localparam wordT markAddr  = 16'h0049;  // After the not-taken BRnp
	localparam wordT linkAddr  = 16'h004A;  // R7 from the subroutine
	localparam wordT retAddr   = 16'h004B;  // First store after JSR
	localparam wordT finalAddr = 16'h004C;
	localparam wordT jsrAddr   = 16'd21;
	localparam logic [4:0] andImm = 5'b10110;  // -10
	localparam logic [`LC3_LED_W-1:0] pauseVal = 12'hA5C;

	logic Clk = 1'b0;
	logic rst = 1'b1;
	logic run = 1'b0;
	logic resume = 1'b0;
	wordT memRdData, memAddr, memWrData;
	logic memOe, memWe;
	logic [`LC3_LED_W-1:0] ledOut;

	wordT mem [256];
	wordT dataW [4];
	wordT expAdd, expAnd, expAndI, expNot;
	logic [31:0] rngState;
	logic seenMarker = 1'b0;
	logic seenReturn = 1'b0;
	logic seenLink = 1'b0;
	logic resumeDone = 1'b0;
	int cycleCount = 0;

	lc3Top i_dut (
		.Clk, .rst, .run, .resume, .memRdData,
		.memAddr, .memWrData, .memOe, .memWe, .ledOut
	);

	always #20 Clk = ~Clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic reportFailure(input string msg);
		$display("[FAIL] time %0d ns: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at first error");
	endtask

	// --------------------
	// Memory model
	// --------------------
	assign memRdData = mem[memAddr[7:0]];  // Combinational read

	always @(posedge Clk)
	begin
		if (memWe) mem[memAddr[7:0]] <= memWrData;
		if (memWe && memAddr == markAddr) seenMarker <= 1'b1;
		if (memWe && memAddr == retAddr) seenReturn <= 1'b1;
		if (memWe && memAddr == linkAddr) seenLink <= 1'b1;
	end

	// --------------------
	// Store and pause checks
	// --------------------
	aAdd: assert property (@(posedge Clk) disable iff (rst)
		memWe && memAddr == addAddr |-> memWrData == expAdd)
		else reportFailure("ADD result store mismatch");
	aAnd: assert property (@(posedge Clk) disable iff (rst)
		memWe && memAddr == andAddr |-> memWrData == expAnd)
		else reportFailure("AND result store mismatch");
	aAndI: assert property (@(posedge Clk) disable iff (rst)
		memWe && memAddr == andIAddr |-> memWrData == expAndI)
		else reportFailure("AND immediate result store mismatch");
	aNot: assert property (@(posedge Clk) disable iff (rst)
		memWe && memAddr == notAddr |-> memWrData == expNot)
		else reportFailure("NOT result store mismatch");
	aLink: assert property (@(posedge Clk) disable iff (rst)
		memWe && memAddr == linkAddr |-> memWrData == jsrAddr + 16'd1)
		else reportFailure("JSR link register mismatch");
	aForbid: assert property (@(posedge Clk) disable iff (rst) !(memWe && memAddr == forbidAddr))
		else reportFailure("Taken branch did not skip the forbidden store");
	aLed: assert property (@(posedge Clk) disable iff (rst) $past(i_dut.ldLed) |-> ledOut == pauseVal)
		else reportFailure("ledOut does not show the PAUSE operand");
	aPauseQuiet: assert property (@(posedge Clk) disable iff (rst)
		ledOut == pauseVal && !resumeDone |-> !memOe && !memWe)
		else reportFailure("Memory strobe before resume toggled");

	// Protocol failures from the bound checker
	always @(negedge Clk)
		if (i_dut.i_sva.failCount != 0)
			reportFailure("Memory protocol assertion failed");

	always @(posedge Clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles)
		begin
			$display("Timeout: no final store within %0d cycles", timeoutCycles);
			$display("*** TEST FAILED ***");
			$fatal(1, "Simulation timed out");
		end
	end

	// --------------------
	// Program and stimulus
	// --------------------
	initial
	begin
		rngState = 32'd60;
		for (int i = 0; i < 4; i++)
		begin
			rngState = xorshift32(rngState);
			dataW[i] = rngState[15:0];
		end
		expAdd  = dataW[0] + dataW[1];
		expAnd  = dataW[2] & dataW[3];
		expAndI = dataW[0] & {{11{andImm[4]}}, andImm};  // imm5 sign extended
		expNot  = ~dataW[1];

		for (int a = 0; a < 256; a++)
			mem[a] <= {4'hF, 4'h0, a[7:0]};  // Unsupported opcode, acts as NOP
		mem[0]  <= 16'h1C28;  // ADD R6, R0, #8
		mem[1]  <= 16'h1D86;  // ADD R6, R6, R6
		mem[2]  <= 16'h1D86;
		mem[3]  <= 16'h1D86;  // R6 = 0x40
		mem[4]  <= 16'h6380;  // LDR R1, R6, #0
		mem[5]  <= 16'h6581;  // LDR R2, R6, #1
		mem[6]  <= 16'h6782;  // LDR R3, R6, #2
		mem[7]  <= 16'h6983;  // LDR R4, R6, #3
		mem[8]  <= 16'h1A42;  // ADD R5, R1, R2
		mem[9]  <= 16'h7B84;  // STR R5, R6, #4
		mem[10] <= 16'h5AC4;  // AND R5, R3, R4
		mem[11] <= 16'h7B85;  // STR R5, R6, #5
		mem[12] <= 16'h5A76;  // AND R5, R1, #-10
		mem[13] <= 16'h7B86;  // STR R5, R6, #6
		mem[14] <= 16'h9ABF;  // NOT R5, R2
		mem[15] <= 16'h7B87;  // STR R5, R6, #7
		mem[16] <= 16'h5B60;  // AND R5, R5, #0 sets Z
		mem[17] <= 16'h0401;  // BRz #1
		mem[18] <= 16'h7D88;  // STR R6, R6, #8 never reached
		mem[19] <= 16'h0A01;  // BRnp #1 falls through
		mem[20] <= 16'h7D89;  // STR R6, R6, #9
		mem[21] <= 16'h4804;  // JSR #4 to address 26
		mem[22] <= 16'h7D8B;  // STR R6, R6, #11
		mem[23] <= 16'hDA5C;  // PAUSE 0xA5C
		mem[24] <= 16'h7D8C;  // STR R6, R6, #12
		mem[25] <= 16'h0FFF;  // BRnzp #-1, spin
		mem[26] <= 16'h7F8A;  // STR R7, R6, #10
		mem[27] <= 16'hC1C0;  // JMP R7
		for (int i = 0; i < 4; i++)
			mem[baseAddr[7:0] + 8'(i)] <= dataW[i];

		repeat (8) @(posedge Clk);
		rst <= 1'b0;
		// Stay halted long enough for a stray fetch to reach memOe
		repeat (4) @(posedge Clk);
		run <= 1'b1;

		// Operator toggles resume once the LEDs show the operand
		do @(negedge Clk); while (ledOut != pauseVal);
		repeat (4) @(posedge Clk);
		resume <= 1'b1;
		repeat (4) @(posedge Clk);
		resume     <= 1'b0;
		resumeDone <= 1'b1;

		do @(negedge Clk); while (!(memWe && memAddr == finalAddr));
		do @(negedge Clk); while (memWe);

		assert (seenMarker) else reportFailure("Not-taken branch skipped the marker store");
		assert (seenLink) else reportFailure("Subroutine never stored R7");
		assert (seenReturn) else reportFailure("Execution did not continue after JSR");
		if (i_dut.i_sva.failCount == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			reportFailure("Memory protocol assertion failed");
	end

endmodule

// File: test/lc3_sva.sv
// Memory strobe protocol checks
`include "lc3_consts.svh"

module lc3Sva
	import lc3IsaPkg::*;
(
	input logic Clk,
	input logic rst,
	input logic run,
	input logic memOe,
	input logic memWe,
	input wordT memAddr,
	input wordT memWrData,
	input logic ldMar,
	input logic ldMdr,
	input logic ldIr,
	input logic ldPc,
	input logic ldReg
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;  // Polled from the testbench
	int oeLen;          // Strobe high cycles so far
	int weLen;
	logic seenRead;     // Any read burst since reset

	task automatic flagError(input string msg);
		$error("%s", msg);
		failCount = failCount + 1;
	endtask

	// --------------------
	// Burst length tracking
	// --------------------
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			oeLen    <= 0;
			weLen    <= 0;
			seenRead <= 1'b0;
		end
		else
		begin
			oeLen <= memOe ? oeLen + 1 : 0;
			weLen <= memWe ? weLen + 1 : 0;
			if (memOe) seenRead <= 1'b1;
		end
	end

	// Quiet controller right after reset
	aResetQuiet: assert property (@(posedge Clk)
		$past(rst) |-> !memOe && !memWe && !ldMar && !ldMdr && !ldIr && !ldPc && !ldReg)
		else flagError("Control or strobe active in reset");
	aHaltQuiet: assert property (@(posedge Clk) !run |-> !memOe && !memWe)
		else flagError("Memory strobe while halted");  // run stays high once raised
	aExclusive: assert property (@(posedge Clk) disable iff (rst) !(memOe && memWe))
		else flagError("memOe and memWe high together");

	// --------------------
	// Burst shape
	// --------------------
	aOeMax: assert property (@(posedge Clk) disable iff (rst) memOe |-> oeLen < `LC3_MEM_WAIT)
		else flagError("Read burst too long");
	aOeLen: assert property (@(posedge Clk) disable iff (rst)
		$fell(memOe) |-> oeLen == `LC3_MEM_WAIT)
		else flagError("Read burst too short");
	aWeMax: assert property (@(posedge Clk) disable iff (rst) memWe |-> weLen < `LC3_MEM_WAIT)
		else flagError("Write burst too long");
	aWeLen: assert property (@(posedge Clk) disable iff (rst)
		$fell(memWe) |-> weLen == `LC3_MEM_WAIT)
		else flagError("Write burst too short");
	aOeStable: assert property (@(posedge Clk) disable iff (rst)
		memOe && $past(memOe) |-> $stable(memAddr))
		else flagError("memAddr moved during read");
	aWeStable: assert property (@(posedge Clk) disable iff (rst)
		memWe && $past(memWe) |-> $stable(memAddr) && $stable(memWrData))
		else flagError("memAddr or memWrData moved during write");
	aBootAddr: assert property (@(posedge Clk) disable iff (rst)
		memOe && !seenRead |-> memAddr == '0)  // First fetch from zero
		else flagError("First read not at address zero");

endmodule

bind lc3Top lc3Sva i_sva (
	.Clk, .rst, .run, .memOe, .memWe, .memAddr, .memWrData,
	.ldMar, .ldMdr, .ldIr, .ldPc, .ldReg
);

// File: hw/lc3Top.sv
// LC-3 subset processor top level
`include "lc3_consts.svh"

module lc3Top
	import lc3IsaPkg::*, lc3CtrlPkg::*;
(
	input  logic Clk,
	input  logic rst,
	input  logic run,
	input  logic resume,
	input  wordT memRdData,
	output wordT memAddr,
	output wordT memWrData,
	output logic memOe,
	output logic memWe,
	output logic [`LC3_LED_W-1:0] ledOut
);

	// Controller to datapath
	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	logic gatePc, gateMdr, gateAlu, gateMarMux;
	logic drMux, sr1Mux, sr2Mux;
	pcMuxT    pcMux;
	addr1MuxT addr1Mux;
	addr2MuxT addr2Mux;
	alukT     aluk;

	// Datapath to controller
	opcodeT opcode;
	logic   ir5, ir11, ben;

	// Register file
	logic   regLd;
	regIdxT drIdx, sr1Idx, sr2Idx;
	wordT   busOut, sr1Out, sr2Out;

	isdu i_isdu (
		.Clk, .rst, .run, .resume, .opcode, .ir5, .ir11, .ben,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc, .ldLed,
		.gatePc, .gateMdr, .gateAlu, .gateMarMux,
		.pcMux, .drMux, .sr1Mux, .sr2Mux, .addr1Mux, .addr2Mux, .aluk,
		.memOe, .memWe
	);

	lc3Datapath i_datapath (
		.Clk, .rst,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc, .ldLed,
		.gatePc, .gateMdr, .gateAlu, .gateMarMux,
		.pcMux, .drMux, .sr1Mux, .sr2Mux, .addr1Mux, .addr2Mux, .aluk,
		.memOe, .memRdData, .sr1Out, .sr2Out,
		.opcode, .ir5, .ir11, .ben,
		.regLd, .drIdx, .sr1Idx, .sr2Idx, .busOut,
		.memAddr, .memWrData, .ledOut
	);

	lc3RegFile i_regFile (
		.Clk, .rst,
		.ld    (regLd),
		.drIdx, .sr1Idx, .sr2Idx,
		.busIn (busOut),
		.sr1Out, .sr2Out
	);

endmodule

// File: hw/lc3Datapath.sv
// LC-3 datapath
`include "lc3_consts.svh"

module lc3Datapath
	import lc3IsaPkg::*, lc3CtrlPkg::*;
(
	input  logic     Clk,
	input  logic     rst,
	input  logic     ldMar,
	input  logic     ldMdr,
	input  logic     ldIr,
	input  logic     ldBen,
	input  logic     ldCc,
	input  logic     ldReg,
	input  logic     ldPc,
	input  logic     ldLed,
	input  logic     gatePc,
	input  logic     gateMdr,
	input  logic     gateAlu,
	input  logic     gateMarMux,
	input  pcMuxT    pcMux,
	input  logic     drMux,
	input  logic     sr1Mux,
	input  logic     sr2Mux,
	input  addr1MuxT addr1Mux,
	input  addr2MuxT addr2Mux,
	input  alukT     aluk,
	input  logic     memOe,      // MDR source select
	input  wordT     memRdData,
	input  wordT     sr1Out,
	input  wordT     sr2Out,
	output opcodeT   opcode,
	output logic     ir5,
	output logic     ir11,
	output logic     ben,
	output logic     regLd,
	output regIdxT   drIdx,
	output regIdxT   sr1Idx,
	output regIdxT   sr2Idx,
	output wordT     busOut,
	output wordT     memAddr,
	output wordT     memWrData,
	output logic [`LC3_LED_W-1:0] ledOut
);

	wordT pc, ir, mar, mdr;
	nzpT  nzp;
	wordT adderBase, adderOff, adderOut;
	wordT aluB, aluOut;
	wordT pcNext;

	// --------------------
	// Address adder
	// --------------------
	assign adderBase = (addr1Mux == a1Sr1) ? sr1Out : pc;

	always_comb
	begin
		unique case (addr2Mux)
			a2Off6:  adderOff = {{(`LC3_WORD_W-6){ir[5]}}, ir[5:0]};
			a2Off9:  adderOff = {{(`LC3_WORD_W-9){ir[8]}}, ir[8:0]};
			a2Off11: adderOff = {{(`LC3_WORD_W-11){ir[10]}}, ir[10:0]};
			default: adderOff = '0;  // a2Zero
		endcase
	end

	assign adderOut = adderBase + adderOff;

	// --------------------
	// ALU
	// --------------------
	assign aluB = sr2Mux ? {{(`LC3_WORD_W-5){ir[4]}}, ir[4:0]} : sr2Out;  // imm5 or SR2

	always_comb
	begin
		unique case (aluk)
			alukAdd: aluOut = sr1Out + aluB;
			alukAnd: aluOut = sr1Out & aluB;
			alukNot: aluOut = ~sr1Out;
			default: aluOut = sr1Out;  // Pass
		endcase
	end

	// Bus, one gate at a time, zero when idle
	always_comb
	begin
		unique case ({gatePc, gateMdr, gateAlu, gateMarMux})
			4'b1000: busOut = pc;
			4'b0100: busOut = mdr;
			4'b0010: busOut = aluOut;
			4'b0001: busOut = adderOut;
			default: busOut = '0;
		endcase
	end

	always_comb
	begin
		unique case (pcMux)
			pcBus:   pcNext = busOut;
			pcAddr:  pcNext = adderOut;
			default: pcNext = pc + 1'b1;
		endcase
	end

	// --------------------
	// Registers
	// --------------------
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			pc     <= '0;  // Boot from address zero
			ir     <= '0;
			nzp    <= '0;
			ben    <= 1'b0;
			ledOut <= '0;
		end
		else
		begin
			if (ldPc) pc <= pcNext;
			if (ldIr) ir <= busOut;
			if (ldCc)
			begin
				nzp.n <= busOut[`LC3_WORD_W-1];
				nzp.z <= (busOut == '0);
				nzp.p <= !busOut[`LC3_WORD_W-1] && (busOut != '0);
			end
			// Branch when any requested flag is set
			if (ldBen) ben <= |(ir[11:9] & {nzp.n, nzp.z, nzp.p});
			if (ldLed) ledOut <= ir[`LC3_LED_W-1:0];
		end
	end

	// Memory interface registers
	always_ff @(posedge Clk)
	begin
		if (ldMar) mar <= busOut;
		if (ldMdr) mdr <= memOe ? memRdData : busOut;  // Read data or store value
	end

	assign memAddr   = mar;
	assign memWrData = mdr;

	// Decode fields back to the controller
	assign opcode = opcodeT'(ir[15:12]);
	assign ir5    = ir[5];
	assign ir11   = ir[11];

	// Register file indices
	assign regLd  = ldReg;
	assign drIdx  = drMux ? 3'd7 : ir[11:9];   // R7 for JSR link
	assign sr1Idx = sr1Mux ? ir[11:9] : ir[8:6];  // SR of STR or BaseR/SR1
	assign sr2Idx = ir[2:0];

endmodule

// File: hw/lc3RegFile.sv
// General register file
`include "lc3_consts.svh"

module lc3RegFile
	import lc3IsaPkg::*;
(
	input  logic   Clk,
	input  logic   rst,
	input  logic   ld,      // Write enable
	input  regIdxT drIdx,   // Write index
	input  regIdxT sr1Idx,
	input  regIdxT sr2Idx,
	input  wordT   busIn,   // Write data from the bus
	output wordT   sr1Out,
	output wordT   sr2Out
);

	wordT regs [`LC3_NUM_REGS];

	// One write port
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `LC3_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (ld)
			regs[drIdx] <= busIn;
	end

	// Two combinational read ports
	assign sr1Out = regs[sr1Idx];
	assign sr2Out = regs[sr2Idx];

endmodule

// File: hw/isdu.sv
// Instruction sequencing and decode unit
`include "lc3_consts.svh"

module isdu
	import lc3IsaPkg::*, lc3CtrlPkg::*;
(
	input  logic     Clk,
	input  logic     rst,
	input  logic     run,        // Leave halted
	input  logic     resume,     // Operator toggle for PAUSE
	input  opcodeT   opcode,
	input  logic     ir5,        // Immediate form of ADD/AND
	input  logic     ir11,       // JSR form bit
	input  logic     ben,
	output logic     ldMar,
	output logic     ldMdr,
	output logic     ldIr,
	output logic     ldBen,
	output logic     ldCc,
	output logic     ldReg,
	output logic     ldPc,
	output logic     ldLed,
	output logic     gatePc,
	output logic     gateMdr,
	output logic     gateAlu,
	output logic     gateMarMux,
	output pcMuxT    pcMux,
	output logic     drMux,      // 1 selects R7
	output logic     sr1Mux,     // 1 selects IR[11:9]
	output logic     sr2Mux,     // 1 selects imm5
	output addr1MuxT addr1Mux,
	output addr2MuxT addr2Mux,
	output alukT     aluk,
	output logic     memOe,
	output logic     memWe
);

	localparam int WaitW = $clog2(`LC3_MEM_WAIT + 1);

	typedef enum logic [4:0] {
		sHalted, sFetch, sMemWait, sIrLoad, sDecode,
		sAdd, sAnd, sNot,
		sLdrAddr, sLdrWait, sLdrWb,
		sStrAddr, sStrMdr, sStrWait, sStrIdle,
		sBr, sBrTaken, sJmp, sJsrLink, sJsrJump,
		sPause1, sPause2
	} stateT;

	stateT state, nextState;
	logic [WaitW-1:0] waitCnt;  // Cycles left in the current burst
	logic lastWait;

	assign lastWait = (waitCnt == WaitW'(1));

	// --------------------
	// State and wait counter
	// --------------------
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state   <= sHalted;
			waitCnt <= '0;
		end
		else
		begin
			state <= nextState;
			// Each of these states always precedes a burst
			if (state == sFetch || state == sLdrAddr || state == sStrMdr)
				waitCnt <= WaitW'(`LC3_MEM_WAIT);
			else if (waitCnt != '0)
				waitCnt <= waitCnt - 1'b1;
		end
	end

	// --------------------
	// Next state
	// --------------------
	always_comb
	begin
		nextState = state;
		unique case (state)
			sHalted:  if (run) nextState = sFetch;
			sFetch:   nextState = sMemWait;
			sMemWait: if (lastWait) nextState = sIrLoad;  // Hold memOe for the burst
			sIrLoad:  nextState = sDecode;
			sDecode:
				case (opcode)
					opAdd:   nextState = sAdd;
					opAnd:   nextState = sAnd;
					opNot:   nextState = sNot;
					opLdr:   nextState = sLdrAddr;
					opStr:   nextState = sStrAddr;
					opBr:    nextState = sBr;
					opJmp:   nextState = sJmp;
					opJsr:   nextState = ir11 ? sJsrLink : sFetch;  // JSRR not supported
					opPause: nextState = sPause1;
					default: nextState = sFetch;
				endcase
			sLdrAddr: nextState = sLdrWait;
			sLdrWait: if (lastWait) nextState = sLdrWb;
			sStrAddr: nextState = sStrMdr;
			sStrMdr:  nextState = sStrWait;
			sStrWait: if (lastWait) nextState = sStrIdle;
			sBr:      nextState = ben ? sBrTaken : sFetch;
			sJsrLink: nextState = sJsrJump;
			sPause1:  if (resume) nextState = sPause2;   // Wait for press
			sPause2:  if (!resume) nextState = sFetch;   // Wait for release
			default:  nextState = sFetch;  // Single-cycle executes and sStrIdle
		endcase
	end

	// --------------------
	// Control outputs
	// --------------------
	always_comb
	begin
		ldMar      = 1'b0;
		ldMdr      = 1'b0;
		ldIr       = 1'b0;
		ldBen      = 1'b0;
		ldCc       = 1'b0;
		ldReg      = 1'b0;
		ldPc       = 1'b0;
		ldLed      = 1'b0;
		gatePc     = 1'b0;
		gateMdr    = 1'b0;
		gateAlu    = 1'b0;
		gateMarMux = 1'b0;
		pcMux      = pcInc;
		drMux      = 1'b0;
		sr1Mux     = 1'b0;
		sr2Mux     = 1'b0;
		addr1Mux   = a1Pc;
		addr2Mux   = a2Zero;
		aluk       = alukAdd;
		memOe      = 1'b0;
		memWe      = 1'b0;

		unique case (state)
			sFetch:  // MAR <- PC, PC <- PC + 1
			begin
				gatePc = 1'b1;
				ldMar  = 1'b1;
				ldPc   = 1'b1;
			end
			sMemWait, sLdrWait:  // MDR <- M[MAR] on the last cycle
			begin
				memOe = 1'b1;
				ldMdr = lastWait;
			end
			sIrLoad:  // IR <- MDR
			begin
				gateMdr = 1'b1;
				ldIr    = 1'b1;
			end
			sDecode: ldBen = 1'b1;
			sAdd, sAnd, sNot:  // DR <- SR1 op OP2, set CC
			begin
				sr2Mux  = ir5;
				aluk    = (state == sAdd) ? alukAdd : (state == sAnd) ? alukAnd : alukNot;
				gateAlu = 1'b1;
				ldReg   = 1'b1;
				ldCc    = 1'b1;
			end
			sLdrAddr, sStrAddr:  // MAR <- BaseR + off6
			begin
				addr1Mux   = a1Sr1;
				addr2Mux   = a2Off6;
				gateMarMux = 1'b1;
				ldMar      = 1'b1;
			end
			sLdrWb:  // DR <- MDR, set CC
			begin
				gateMdr = 1'b1;
				ldReg   = 1'b1;
				ldCc    = 1'b1;
			end
			sStrMdr:  // MDR <- SR through the ALU
			begin
				sr1Mux  = 1'b1;
				aluk    = alukPass;
				gateAlu = 1'b1;
				ldMdr   = 1'b1;
			end
			sStrWait: memWe = 1'b1;
			sBrTaken:  // PC <- PC + off9
			begin
				addr2Mux = a2Off9;
				pcMux    = pcAddr;
				ldPc     = 1'b1;
			end
			sJmp:  // PC <- BaseR
			begin
				addr1Mux = a1Sr1;
				pcMux    = pcAddr;
				ldPc     = 1'b1;
			end
			sJsrLink:  // R7 <- PC
			begin
				gatePc = 1'b1;
				drMux  = 1'b1;
				ldReg  = 1'b1;
			end
			sJsrJump:  // PC <- PC + off11
			begin
				addr2Mux = a2Off11;
				pcMux    = pcAddr;
				ldPc     = 1'b1;
			end
			sPause1: ldLed = 1'b1;  // Show IR[11:0]
			default: ;  // sHalted, sBr, sStrIdle, sPause2 drive nothing
		endcase
	end

endmodule

// File: hw/lc3CtrlPkg.sv
// LC-3 datapath select types
package lc3CtrlPkg;

	// Next PC source
	typedef enum logic [1:0] {
		pcInc  = 2'b00,  // PC + 1
		pcBus  = 2'b01,  // From the bus
		pcAddr = 2'b10   // From the address adder
	} pcMuxT;

	// Address adder base
	typedef enum logic {
		a1Pc  = 1'b0,
		a1Sr1 = 1'b1   // Register file SR1 output
	} addr1MuxT;

	// Address adder offset, sign extended from IR
	typedef enum logic [1:0] {
		a2Zero  = 2'b00,
		a2Off6  = 2'b01,  // IR[5:0]
		a2Off9  = 2'b10,  // IR[8:0]
		a2Off11 = 2'b11   // IR[10:0]
	} addr2MuxT;

	// ALU function
	typedef enum logic [1:0] {
		alukAdd  = 2'b00,
		alukAnd  = 2'b01,
		alukNot  = 2'b10,
		alukPass = 2'b11  // SR1 straight through
	} alukT;

endpackage

// File: hw/lc3IsaPkg.sv
// LC-3 instruction encoding types
`include "lc3_consts.svh"

package lc3IsaPkg;

	// One machine word, also used for addresses
	typedef logic [`LC3_WORD_W-1:0] wordT;

	// Register number, R0 to R7
	typedef logic [2:0] regIdxT;

	// --------------------
	// Opcodes, IR[15:12]
	// --------------------
	// Anything not named here falls back to fetch
	typedef enum logic [3:0] {
		opBr    = 4'b0000,  // BR with nzp mask
		opAdd   = 4'b0001,  // ADD, reg or imm5
		opJsr   = 4'b0100,  // JSR, PC-relative only
		opAnd   = 4'b0101,  // AND, reg or imm5
		opLdr   = 4'b0110,  // DR <- M[BaseR + off6]
		opStr   = 4'b0111,  // M[BaseR + off6] <- SR
		opNot   = 4'b1001,
		opJmp   = 4'b1100,  // Also RET when BaseR is R7
		opPause = 4'b1101   // Show IR[11:0], wait for resume
	} opcodeT;

	// Condition flags
	typedef struct packed {
		logic n;  // Negative
		logic z;  // Zero
		logic p;  // Positive
	} nzpT;

endpackage

// File: include/lc3_consts.svh
// LC-3 subset constants
`ifndef LC3_CONSTS_SVH
`define LC3_CONSTS_SVH

// --------------------
// Word and register file
// --------------------
`define LC3_WORD_W 16   // Data and address width
`define LC3_NUM_REGS 8  // R0 to R7

// --------------------
// Memory timing
// --------------------
// Cycles a read or write strobe stays high per transfer
`define LC3_MEM_WAIT 3

// --------------------
// Pause display
// --------------------
`define LC3_LED_W 12    // IR[11:0] shown during PAUSE

`endif
